//--- design/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    // Byte address layout is tag [15:11], set index [10:3], word [2:1], byte [0].
    localparam int addr_w         = 16;
    localparam int data_w         = 16;
    localparam int tag_w          = 5;
    localparam int index_w        = 8;
    localparam int word_sel_w     = 2;
    localparam int words_per_line = 4;
    localparam int num_ways       = 2;

    typedef logic [addr_w-1:0]     addr_t;
    typedef logic [data_w-1:0]     word_t;
    typedef logic [tag_w-1:0]      tag_t;
    typedef logic [index_w-1:0]    index_t;
    typedef logic [word_sel_w-1:0] word_sel_t;

endpackage

`default_nettype wire

//--- design/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

    // The write-back states walk the victim line one word per cycle.
    // The fill states overlap memory reads (fill_0..fill_3) with way writes (fill_2..fill_5).
    typedef enum logic [3:0] {
        idle,
        compare,
        wb_0, wb_1, wb_2, wb_3,
        fill_0, fill_1, fill_2, fill_3, fill_4, fill_5
    } ctrl_state_t;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } req_op_t;

endpackage

`default_nettype wire

//--- design/cache_way.sv
`default_nettype none
`timescale 1ns/1ps

module cache_way (
    input  logic                      clk,
    input  logic                      reset,
    input  cache_geom_pkg::index_t    way_index,
    input  cache_geom_pkg::word_sel_t way_word,
    input  cache_geom_pkg::tag_t      way_cmp_tag,
    input  logic                      way_write,
    input  logic                      way_set_valid,
    input  logic                      way_set_dirty,
    input  cache_geom_pkg::tag_t      way_wtag,
    input  cache_geom_pkg::word_t     way_wdata,
    output logic                      way_hit,
    output logic                      way_valid,
    output logic                      way_dirty,
    output cache_geom_pkg::tag_t      way_tag,
    output cache_geom_pkg::word_t     way_rdata
);
    import cache_geom_pkg::*;

    logic [2**index_w-1:0] valid_bits;
    logic [2**index_w-1:0] dirty_bits;
    tag_t                  tag_mem  [2**index_w];
    word_t                 data_mem [2**index_w][words_per_line];

    // All lookups are combinational at the index and word presented.
    assign way_valid = valid_bits[way_index];
    assign way_dirty = dirty_bits[way_index];
    assign way_tag   = tag_mem[way_index];
    assign way_rdata = data_mem[way_index][way_word];
    assign way_hit   = way_valid && (way_tag == way_cmp_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (way_write && way_set_valid) begin
            valid_bits[way_index] <= 1'b1;
        end
    end

    // A line install loads tag and dirty together; a plain store only marks dirty.
    always_ff @(posedge clk) begin
        if (way_write) begin
            data_mem[way_index][way_word] <= way_wdata;
            if (way_set_valid) begin
                tag_mem[way_index]    <= way_wtag;
                dirty_bits[way_index] <= way_set_dirty;
            end else if (way_set_dirty) begin
                dirty_bits[way_index] <= 1'b1;
            end
        end
    end

    // A line is installed only when no way of the set already holds its tag.
    a_no_duplicate_install: assert property (
        @(posedge clk) disable iff (reset) way_set_valid |-> !way_hit
    );

endmodule

`default_nettype wire

//--- design/way_select.sv
`default_nettype none
`timescale 1ns/1ps

module way_select (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic [cache_geom_pkg::num_ways-1:0]                  way_hit,
    input  logic [cache_geom_pkg::num_ways-1:0]                  way_valid,
    input  logic [cache_geom_pkg::num_ways-1:0]                  way_dirty,
    input  cache_geom_pkg::tag_t [cache_geom_pkg::num_ways-1:0]  way_tag,
    input  cache_geom_pkg::word_t [cache_geom_pkg::num_ways-1:0] way_rdata,
    input  logic                                                 wb_phase,
    input  cache_geom_pkg::index_t                               lru_index,
    input  logic                                                 lru_touch,
    input  logic                                                 lru_way,
    output logic                                                 hit,
    output logic                                                 hit_way,
    output logic                                                 victim_way,
    output logic                                                 victim_dirty_valid,
    output cache_geom_pkg::tag_t                                 victim_tag,
    output cache_geom_pkg::word_t                                sel_rdata
);
    import cache_geom_pkg::*;

    // Each bit names the least recently used way of its set.
    logic [2**index_w-1:0] lru_bits;

    always_comb begin
        hit     = |way_hit;
        hit_way = 1'b0;
        for (int i = 0; i < num_ways; i++) begin
            if (way_hit[i]) begin
                hit_way = 1'(i);
            end
        end
        if (!way_valid[0]) begin
            victim_way = 1'b0;
        end else if (!way_valid[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_bits[lru_index];
        end
        victim_dirty_valid = way_valid[victim_way] && way_dirty[victim_way];
        victim_tag         = way_tag[victim_way];
        sel_rdata          = wb_phase ? way_rdata[victim_way] : way_rdata[hit_way];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits <= '0;
        end else if (lru_touch) begin
            lru_bits[lru_index] <= ~lru_way;
        end
    end

    // A tag lives in at most one way of a set.
    a_single_hit: assert property (
        @(posedge clk) disable iff (reset) $onehot0(way_hit)
    );

endmodule

`default_nettype wire

//--- design/cache_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       req_valid,
    input  cache_ctrl_pkg::req_op_t                    req_op,
    input  cache_geom_pkg::addr_t                      req_addr,
    input  cache_geom_pkg::word_t                      req_wdata,
    input  logic                                       hit,
    input  logic                                       hit_way,
    input  logic                                       victim_way,
    input  logic                                       victim_dirty_valid,
    input  cache_geom_pkg::tag_t                       victim_tag,
    input  cache_geom_pkg::word_t                      sel_rdata,
    input  cache_geom_pkg::word_t                      mem_rdata,
    output logic                                       req_ready,
    output logic                                       resp_valid,
    output cache_geom_pkg::word_t                      resp_rdata,
    output logic                                       resp_hit,
    output cache_geom_pkg::index_t                     way_index,
    output cache_geom_pkg::word_sel_t                  way_word,
    output cache_geom_pkg::tag_t                       way_wtag,
    output cache_geom_pkg::word_t                      way_wdata,
    output logic                                       way_set_valid,
    output logic                                       way_set_dirty,
    output logic [cache_geom_pkg::num_ways-1:0]        way_write,
    output logic                                       wb_phase,
    output logic                                       lru_touch,
    output logic                                       lru_way,
    output logic                                       mem_read,
    output logic                                       mem_write,
    output cache_geom_pkg::addr_t                      mem_addr,
    output cache_geom_pkg::word_t                      mem_wdata
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    req_op_t   op_q;
    tag_t      tag_q;
    index_t    index_q;
    word_sel_t word_q;
    word_t     wdata_q;
    logic      victim_q;
    word_t     mem_rdata_q;
    word_t     rdata_q;

    word_sel_t seq_word;
    word_sel_t fill_wr_word;
    logic      fill_rd;
    logic      fill_wr;
    logic      fill_match;

    // ------------------------------------------------------------------------
    // Word sequencing for the write-back and refill states
    // ------------------------------------------------------------------------
    always_comb begin
        seq_word     = '0;
        fill_wr_word = '0;
        case (state)
            wb_1, fill_1: seq_word = 2'd1;
            wb_2, fill_2: seq_word = 2'd2;
            wb_3, fill_3: seq_word = 2'd3;
            default:      seq_word = 2'd0;
        endcase
        case (state)
            fill_3:  fill_wr_word = 2'd1;
            fill_4:  fill_wr_word = 2'd2;
            fill_5:  fill_wr_word = 2'd3;
            default: fill_wr_word = 2'd0;
        endcase
    end

    assign fill_rd    = state inside {fill_0, fill_1, fill_2, fill_3};
    assign fill_wr    = state inside {fill_2, fill_3, fill_4, fill_5};
    assign fill_match = fill_wr && (fill_wr_word == word_q);

    assign req_ready = (state == idle);
    assign way_index = index_q;
    assign way_wtag  = tag_q;

    // ------------------------------------------------------------------------
    // Next state and outputs
    // ------------------------------------------------------------------------
    always_comb begin
        next_state    = state;
        resp_valid    = 1'b0;
        resp_hit      = 1'b0;
        resp_rdata    = rdata_q;
        way_word      = word_q;
        way_wdata     = wdata_q;
        way_set_valid = 1'b0;
        way_set_dirty = 1'b0;
        way_write     = '0;
        wb_phase      = 1'b0;
        lru_touch     = 1'b0;
        lru_way       = victim_q;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        mem_addr      = {tag_q, index_q, seq_word, 1'b0};
        mem_wdata     = sel_rdata;

        case (state)
            idle: begin
                if (req_valid) begin
                    next_state = compare;
                end
            end
            compare: begin
                resp_rdata = sel_rdata;
                if (hit) begin
                    resp_valid = 1'b1;
                    resp_hit   = 1'b1;
                    lru_touch  = 1'b1;
                    lru_way    = hit_way;
                    if (op_q == op_write) begin
                        way_write[hit_way] = 1'b1;
                        way_set_dirty      = 1'b1;
                    end
                    next_state = idle;
                end else if (victim_dirty_valid) begin
                    next_state = wb_0;
                end else begin
                    next_state = fill_0;
                end
            end
            wb_0, wb_1, wb_2, wb_3: begin
                wb_phase  = 1'b1;
                way_word  = seq_word;
                mem_write = 1'b1;
                mem_addr  = {victim_tag, index_q, seq_word, 1'b0};
                next_state = (state == wb_3) ? fill_0 : ctrl_state_t'(state + 4'd1);
            end
            fill_0, fill_1, fill_2, fill_3, fill_4, fill_5: begin
                mem_read = fill_rd;
                if (fill_wr) begin
                    way_write[victim_q] = 1'b1;
                    way_word            = fill_wr_word;
                    way_wdata = (fill_match && op_q == op_write) ? wdata_q : mem_rdata_q;
                end
                if (state == fill_5) begin
                    way_set_valid = 1'b1;
                    way_set_dirty = (op_q == op_write);
                    lru_touch     = 1'b1;
                    resp_valid    = 1'b1;
                    resp_rdata    = fill_match ? mem_rdata_q : rdata_q;
                    next_state    = idle;
                end else begin
                    next_state = ctrl_state_t'(state + 4'd1);
                end
            end
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // Memory data is staged once so that the fill writes line up with fill_2..fill_5.
    always_ff @(posedge clk) begin
        mem_rdata_q <= mem_rdata;
        if (req_valid && req_ready) begin
            op_q    <= req_op;
            tag_q   <= req_addr[addr_w-1 -: tag_w];
            index_q <= req_addr[addr_w-tag_w-1 -: index_w];
            word_q  <= req_addr[word_sel_w:1];
            wdata_q <= req_wdata;
        end
        if (state == compare) begin
            victim_q <= victim_way;
        end
        if (fill_match) begin
            rdata_q <= mem_rdata_q;
        end
    end

    // Write-back runs only while the selector still reports a valid and dirty victim.
    a_wb_dirty_victim: assert property (
        @(posedge clk) disable iff (reset) wb_phase |-> victim_dirty_valid
    );

    // The selector keeps naming the way latched at compare until the fill ends.
    a_victim_held: assert property (
        @(posedge clk) disable iff (reset)
            (wb_phase || fill_wr) |-> (victim_way == victim_q)
    );

endmodule

`default_nettype wire

//--- design/main_mem.sv
`default_nettype none
`timescale 1ns/1ps

module main_mem #(
    parameter int mem_words = 32768
) (
    input  logic                  clk,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  cache_geom_pkg::addr_t mem_addr,
    input  cache_geom_pkg::word_t mem_wdata,
    output cache_geom_pkg::word_t mem_rdata
);
    import cache_geom_pkg::*;

    localparam int mem_aw = $clog2(mem_words);

    word_t             mem_array [mem_words];
    logic [mem_aw-1:0] word_addr;

    // Memory is word addressed, so the byte bit is dropped.
    assign word_addr = mem_addr[mem_aw:1];

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem_array[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem_array[word_addr] <= mem_wdata;
        end
        if (mem_read) begin
            mem_rdata <= mem_array[word_addr];
        end
    end

endmodule

`default_nettype wire

//--- design/mem_system.sv
`default_nettype none
`timescale 1ns/1ps

module mem_system #(
    parameter int mem_words = 32768
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    input  cache_ctrl_pkg::req_op_t req_op,
    input  cache_geom_pkg::addr_t   req_addr,
    input  cache_geom_pkg::word_t   req_wdata,
    output logic                    req_ready,
    output logic                    resp_valid,
    output cache_geom_pkg::word_t   resp_rdata,
    output logic                    resp_hit
);
    import cache_geom_pkg::*;

    index_t               way_index;
    word_sel_t            way_word;
    tag_t                 way_wtag;
    word_t                way_wdata;
    logic                 way_set_valid;
    logic                 way_set_dirty;
    logic [num_ways-1:0]  way_write;
    logic [num_ways-1:0]  way_hit;
    logic [num_ways-1:0]  way_valid;
    logic [num_ways-1:0]  way_dirty;
    tag_t [num_ways-1:0]  way_tag;
    word_t [num_ways-1:0] way_rdata;

    logic  hit;
    logic  hit_way;
    logic  victim_way;
    logic  victim_dirty_valid;
    tag_t  victim_tag;
    word_t sel_rdata;
    logic  wb_phase;
    logic  lru_touch;
    logic  lru_way;

    logic  mem_read;
    logic  mem_write;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;

    cache_ctrl u_ctrl (.*);

    // The request tag serves as both the compare tag and the install tag.
    for (genvar g = 0; g < num_ways; g++) begin : g_way
        cache_way u_way (
            .clk           (clk),
            .reset         (reset),
            .way_index     (way_index),
            .way_word      (way_word),
            .way_cmp_tag   (way_wtag),
            .way_write     (way_write[g]),
            .way_set_valid (way_set_valid),
            .way_set_dirty (way_set_dirty),
            .way_wtag      (way_wtag),
            .way_wdata     (way_wdata),
            .way_hit       (way_hit[g]),
            .way_valid     (way_valid[g]),
            .way_dirty     (way_dirty[g]),
            .way_tag       (way_tag[g]),
            .way_rdata     (way_rdata[g])
        );
    end

    way_select u_sel (.*, .lru_index(way_index));

    main_mem #(.mem_words(mem_words)) u_mem (.*);

endmodule

`default_nettype wire

//--- sim/tb_mem_system.sv
`default_nettype none
`timescale 1ns/1ps

module tb_mem_system;
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 10;
    localparam int num_requests = 2000;
    localparam int num_directed = 5;
    localparam int max_cycles   = num_requests * 14 + reset_cycles;

    logic    clk;
    logic    reset;
    logic    req_valid;
    req_op_t req_op;
    addr_t   req_addr;
    word_t   req_wdata;
    logic    req_ready;
    logic    resp_valid;
    word_t   resp_rdata;
    logic    resp_hit;

    // Reference state: a flat memory image and the tag state of a two-way cache.
    word_t      shadow_mem [2**(addr_w-1)] = '{default: '0};
    logic [1:0] ref_valid  [2**index_w]    = '{default: '0};
    logic [1:0] ref_dirty  [2**index_w]    = '{default: '0};
    tag_t       ref_tag    [2**index_w][2] = '{default: '0};
    logic       ref_lru    [2**index_w]    = '{default: '0};

    int          cycle     = 0;
    int          errors    = 0;
    int          accepted  = 0;
    int          responses = 0;
    logic        pending   = 1'b0;
    logic [31:0] rng;

    // Expectation for the one request in flight.
    req_op_t exp_op;
    logic    exp_hit;
    word_t   exp_rdata;
    int      exp_lat;
    int      acc_cycle;

    mem_system u_dut (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .resp_hit   (resp_hit)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    // Applies one request and returns its latency: 1 for a hit, 7 for a clean
    // miss, 11 for a miss that first writes back a dirty victim.
    function automatic int model_access(input req_op_t op, input addr_t addr,
                                        input word_t wdata, output logic hit,
                                        output word_t rdata);
        tag_t   tag;
        index_t idx;
        logic   way;
        int     lat;
        tag = addr[15:11];
        idx = addr[10:3];
        hit = 1'b0;
        way = 1'b0;
        lat = 7;
        if (ref_valid[idx][0] && ref_tag[idx][0] == tag) begin
            hit = 1'b1;
            way = 1'b0;
        end else if (ref_valid[idx][1] && ref_tag[idx][1] == tag) begin
            hit = 1'b1;
            way = 1'b1;
        end
        if (hit) begin
            lat = 1;
            if (op == op_write) begin
                ref_dirty[idx][way] = 1'b1;
            end
        end else begin
            if (!ref_valid[idx][0]) begin
                way = 1'b0;
            end else if (!ref_valid[idx][1]) begin
                way = 1'b1;
            end else begin
                way = ref_lru[idx];
            end
            if (ref_valid[idx][way] && ref_dirty[idx][way]) begin
                lat = 11;
            end
            ref_valid[idx][way] = 1'b1;
            ref_tag[idx][way]   = tag;
            ref_dirty[idx][way] = (op == op_write);
        end
        ref_lru[idx] = (way == 1'b0);
        if (op == op_write) begin
            shadow_mem[addr[15:1]] = wdata;
        end
        rdata = shadow_mem[addr[15:1]];
        return lat;
    endfunction

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic addr_t make_addr(input tag_t tag, input index_t idx,
                                        input word_sel_t word, input logic byte_bit);
        return {tag, idx, word, byte_bit};
    endfunction

    // Holds the request on the bus until the edge where the DUT takes it.
    task automatic send_request(input req_op_t op, input addr_t addr, input word_t wdata);
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= addr;
        req_wdata <= wdata;
        do begin
            @(posedge clk);
        end while (!req_ready);
    endtask

    // ------------------------------------------------------------------------
    // Checker
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (!reset) begin
            if (resp_valid) begin
                if (!pending) begin
                    $display("Response arrived with no request outstanding at %0t", $time);
                    errors++;
                end else begin
                    if (cycle - acc_cycle != exp_lat) begin
                        $display("** Error at %0t: latency %0d cycles, expected %0d",
                                 $time, cycle - acc_cycle, exp_lat);
                        errors++;
                    end
                    if (resp_hit !== exp_hit) begin
                        $display("** Error at %0t: resp_hit %b, expected %b",
                                 $time, resp_hit, exp_hit);
                        errors++;
                    end
                    if (exp_op == op_read && resp_rdata !== exp_rdata) begin
                        $display("** Error at %0t: read data %h, expected %h",
                                 $time, resp_rdata, exp_rdata);
                        errors++;
                    end
                end
                pending = 1'b0;
                responses++;
            end
            if (pending && req_ready) begin
                $display("req_ready went high while a request was in progress at %0t", $time);
                errors++;
            end
            if (req_valid && req_ready) begin
                exp_lat   = model_access(req_op, req_addr, req_wdata, exp_hit, exp_rdata);
                exp_op    = req_op;
                acc_cycle = cycle;
                pending   = 1'b1;
                accepted++;
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req_op    = op_read;
        req_addr  = '0;
        req_wdata = '0;
        rng       = 32'd69026;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        if (req_ready !== 1'b1 || resp_valid !== 1'b0) begin
            $display("** Error at %0t: after reset req_ready %b resp_valid %b, expected 1 and 0",
                     $time, req_ready, resp_valid);
            errors++;
        end

        // Three tags in one set; the final read pushes out a dirty line.
        send_request(op_read,  make_addr(5'h03, 8'h5a, 2'd1, 1'b0), 16'h0000);
        send_request(op_write, make_addr(5'h03, 8'h5a, 2'd1, 1'b0), 16'ha1a1);
        send_request(op_write, make_addr(5'h0c, 8'h5a, 2'd2, 1'b0), 16'hb2b2);
        send_request(op_write, make_addr(5'h15, 8'h5a, 2'd0, 1'b1), 16'hc3c3);
        send_request(op_read,  make_addr(5'h03, 8'h5a, 2'd1, 1'b0), 16'h0000);

        // Eight tags over four sets keep conflicts and evictions frequent.
        for (int n = 0; n < num_requests - num_directed; n++) begin
            rng = next_random(rng);
            send_request(req_op_t'(rng[8]),
                         make_addr(tag_t'(rng[2:0]), {rng[4:3], 6'h15}, rng[6:5], rng[7]),
                         rng[31:16]);
        end
        req_valid <= 1'b0;
        @(posedge clk);
        while (pending) begin
            @(posedge clk);
        end

        if (accepted != num_requests || responses != accepted) begin
            $display("Request count mismatch: %0d sent, %0d accepted, %0d responses",
                     num_requests, accepted, responses);
            errors++;
        end
        $display("Run complete: %0d requests, %0d errors", accepted, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_system.f
design/cache_geom_pkg.sv
design/cache_ctrl_pkg.sv
design/cache_way.sv
design/way_select.sv
design/cache_ctrl.sv
design/main_mem.sv
design/mem_system.sv
sim/tb_mem_system.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and checks the log.
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_mem_system -f mem_system.f \
    && ./obj_dir/Vtb_mem_system 2>&1 | tee sim.log \
    || echo "TEST FAILED" >> sim.log

! grep -q "TEST FAILED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
